// ==== common/wbb_pkg.sv ====
`default_nettype none

package wbb_pkg;

  // Data bus width in bits, shared by both adapters.
  localparam int data_width_gp = 64;

  // One select bit per byte lane.
  localparam int sel_width_gp = data_width_gp / 8;

  // Byte offset bits inside a Wishbone word.
  localparam int offset_width_gp = $clog2(sel_width_gp);

  // Message opcode.
  typedef enum logic {
    e_mem_rd = 1'b0,
    e_mem_wr = 1'b1
  } mem_op_e;

  // Access size as log2 of the byte count.
  typedef enum logic [1:0] {
    e_size_1 = 2'd0,
    e_size_2 = 2'd1,
    e_size_4 = 2'd2,
    e_size_8 = 2'd3
  } mem_size_e;

  // Master adapter FSM.
  typedef enum logic [1:0] {
    e_m_idle = 2'd0,
    e_m_bus  = 2'd1,
    e_m_resp = 2'd2
  } master_state_e;

  // Client adapter FSM.
  typedef enum logic [1:0] {
    e_c_idle = 2'd0,
    e_c_fwd  = 2'd1,
    e_c_wait = 2'd2,
    e_c_ack  = 2'd3
  } client_state_e;

  // Low-aligned byte mask covering 2^size bytes.
  function automatic logic [sel_width_gp-1:0] size_to_sel(input mem_size_e size);
    logic [sel_width_gp-1:0] sel;
    sel = '0;
    for (int i = 0; i < sel_width_gp; i++) begin
      if (i < (1 << size)) begin
        sel[i] = 1'b1;
      end
    end
    return sel;
  endfunction

  // Same mask expanded to one bit per data bit.
  function automatic logic [data_width_gp-1:0] size_to_data_mask(input mem_size_e size);
    logic [sel_width_gp-1:0]  sel;
    logic [data_width_gp-1:0] mask;
    sel = size_to_sel(size);
    for (int i = 0; i < sel_width_gp; i++) begin
      mask[8*i+:8] = {8{sel[i]}};
    end
    return mask;
  endfunction

endpackage

`default_nettype wire

// ==== wb_master/mem_fwd_decode.sv ====
`default_nettype none

module mem_fwd_decode
  import wbb_pkg::*;
#(
  parameter  int addr_width_p    = 40,
  localparam int wb_adr_width_lp = addr_width_p - offset_width_gp
) (
  input  logic [addr_width_p-1:0]    fwd_addr_i,
  input  mem_size_e                  fwd_size_i,
  input  logic [data_width_gp-1:0]   fwd_data_i,

  output logic [wb_adr_width_lp-1:0] wb_adr_o,
  output logic [sel_width_gp-1:0]    wb_sel_o,
  output logic [data_width_gp-1:0]   wb_dat_o
);

  logic [offset_width_gp-1:0] byte_offset;
  logic [offset_width_gp+2:0] bit_shift;
  logic [sel_width_gp-1:0]    low_sel;
  logic [data_width_gp-1:0]   low_data;

  // Byte position of the access within the word.
  assign byte_offset = fwd_addr_i[offset_width_gp-1:0];
  assign bit_shift   = {byte_offset, 3'b000};

  // Word address for the bus.
  assign wb_adr_o = fwd_addr_i[addr_width_p-1:offset_width_gp];

  // Mask of 2^size bytes, then moved up to the addressed lanes.
  assign low_sel  = size_to_sel(fwd_size_i);
  assign wb_sel_o = low_sel << byte_offset;

  // Bytes above the size are cleared so the idle lanes stay quiet.
  assign low_data = fwd_data_i & size_to_data_mask(fwd_size_i);
  assign wb_dat_o = low_data << bit_shift;

endmodule

`default_nettype wire

// ==== wb_master/wb_master.sv ====
`default_nettype none

module wb_master
  import wbb_pkg::*;
#(
  parameter  int addr_width_p    = 40,
  localparam int wb_adr_width_lp = addr_width_p - offset_width_gp
) (
  input  logic                       clk_i,
  input  logic                       rst_n_i,

  // Forward message in.
  input  mem_op_e                    fwd_op_i,
  input  logic [addr_width_p-1:0]    fwd_addr_i,
  input  mem_size_e                  fwd_size_i,
  input  logic [data_width_gp-1:0]   fwd_data_i,
  input  logic                       fwd_v_i,
  output logic                       fwd_ready_and_o,

  // Reverse message out.
  output mem_op_e                    rev_op_o,
  output logic [addr_width_p-1:0]    rev_addr_o,
  output mem_size_e                  rev_size_o,
  output logic [data_width_gp-1:0]   rev_data_o,
  output logic                       rev_v_o,
  input  logic                       rev_ready_and_i,

  // Wishbone master side.
  output logic [wb_adr_width_lp-1:0] wb_adr_o,
  output logic [data_width_gp-1:0]   wb_dat_o,
  output logic [sel_width_gp-1:0]    wb_sel_o,
  output logic                       wb_we_o,
  output logic                       wb_cyc_o,
  output logic                       wb_stb_o,
  input  logic [data_width_gp-1:0]   wb_dat_i,
  input  logic                       wb_ack_i
);

  master_state_e state_r, state_n;

  mem_op_e                  op_r;
  logic [addr_width_p-1:0]  addr_r;
  mem_size_e                size_r;
  logic [data_width_gp-1:0] data_r;
  logic [data_width_gp-1:0] rdata_r;

  logic                       fwd_accept;
  logic                       rev_accept;
  logic                       bus_done;
  logic [offset_width_gp+2:0] rd_shift;

  assign fwd_ready_and_o = (state_r == e_m_idle);
  assign fwd_accept      = fwd_v_i & fwd_ready_and_o;
  assign rev_v_o         = (state_r == e_m_resp);
  assign rev_accept      = rev_v_o & rev_ready_and_i;
  assign bus_done        = (state_r == e_m_bus) & wb_ack_i;

  always_comb begin
    state_n = state_r;
    unique case (state_r)
      e_m_idle: if (fwd_accept)  state_n = e_m_bus;
      e_m_bus:  if (wb_ack_i)    state_n = e_m_resp;
      e_m_resp: if (rev_accept)  state_n = e_m_idle;
      default:                   state_n = e_m_idle;
    endcase
  end

  always_ff @(posedge clk_i) begin
    if (!rst_n_i) begin
      state_r <= e_m_idle;
    end else begin
      state_r <= state_n;
    end
  end

  // Request held for the whole bus cycle and the reverse message.
  always_ff @(posedge clk_i) begin
    if (fwd_accept) begin
      op_r   <= fwd_op_i;
      addr_r <= fwd_addr_i;
      size_r <= fwd_size_i;
      data_r <= fwd_data_i;
    end
  end

  mem_fwd_decode #(
    .addr_width_p(addr_width_p)
  ) u_decode (
    .fwd_addr_i(addr_r),
    .fwd_size_i(size_r),
    .fwd_data_i(data_r),
    .wb_adr_o  (wb_adr_o),
    .wb_sel_o  (wb_sel_o),
    .wb_dat_o  (wb_dat_o)
  );

  assign wb_we_o  = (op_r == e_mem_wr);
  assign wb_cyc_o = (state_r == e_m_bus);
  assign wb_stb_o = (state_r == e_m_bus);

  // Read data comes back in its lanes; bring it down and trim to size.
  assign rd_shift = {addr_r[offset_width_gp-1:0], 3'b000};

  always_ff @(posedge clk_i) begin
    if (bus_done) begin
      if (op_r == e_mem_rd) begin
        rdata_r <= (wb_dat_i >> rd_shift) & size_to_data_mask(size_r);
      end else begin
        rdata_r <= '0;
      end
    end
  end

  assign rev_op_o   = op_r;
  assign rev_addr_o = addr_r;
  assign rev_size_o = size_r;
  assign rev_data_o = rdata_r;

endmodule

`default_nettype wire

// ==== wb_client/wb_client.sv ====
`default_nettype none

module wb_client
  import wbb_pkg::*;
#(
  parameter  int addr_width_p    = 40,
  localparam int wb_adr_width_lp = addr_width_p - offset_width_gp
) (
  input  logic                       clk_i,
  input  logic                       rst_n_i,

  // Wishbone slave side.
  input  logic [wb_adr_width_lp-1:0] wb_adr_i,
  input  logic [data_width_gp-1:0]   wb_dat_i,
  input  logic [sel_width_gp-1:0]    wb_sel_i,
  input  logic                       wb_we_i,
  input  logic                       wb_cyc_i,
  input  logic                       wb_stb_i,
  output logic [data_width_gp-1:0]   wb_dat_o,
  output logic                       wb_ack_o,

  // Forward message to the memory.
  output mem_op_e                    fwd_op_o,
  output logic [addr_width_p-1:0]    fwd_addr_o,
  output mem_size_e                  fwd_size_o,
  output logic [data_width_gp-1:0]   fwd_data_o,
  output logic                       fwd_v_o,
  input  logic                       fwd_ready_and_i,

  // Reverse data from the memory.
  input  logic [data_width_gp-1:0]   rev_data_i,
  input  logic                       rev_v_i,
  output logic                       rev_ready_and_o
);

  client_state_e state_r, state_n;

  mem_op_e                  op_r;
  logic [addr_width_p-1:0]  addr_r;
  mem_size_e                size_r;
  logic [data_width_gp-1:0] data_r;
  logic [data_width_gp-1:0] rdata_r;

  logic [offset_width_gp-1:0] sel_offset;
  logic [offset_width_gp:0]   sel_count;
  mem_size_e                  sel_size;
  logic                       bus_start;
  logic                       rev_accept;

  // Lowest select bit gives the byte offset, the bit count gives the size.
  always_comb begin
    sel_offset = '0;
    sel_count  = '0;
    for (int i = sel_width_gp - 1; i >= 0; i--) begin
      if (wb_sel_i[i]) begin
        sel_offset = offset_width_gp'(i);
        sel_count  = sel_count + 1'b1;
      end
    end
    case (sel_count)
      'd1:     sel_size = e_size_1;
      'd2:     sel_size = e_size_2;
      'd4:     sel_size = e_size_4;
      default: sel_size = e_size_8;
    endcase
  end

  assign bus_start       = (state_r == e_c_idle) & wb_cyc_i & wb_stb_i;
  assign fwd_v_o         = (state_r == e_c_fwd);
  assign rev_ready_and_o = (state_r == e_c_wait);
  assign rev_accept      = rev_v_i & rev_ready_and_o;
  assign wb_ack_o        = (state_r == e_c_ack);

  always_comb begin
    state_n = state_r;
    unique case (state_r)
      e_c_idle: if (bus_start)       state_n = e_c_fwd;
      e_c_fwd:  if (fwd_ready_and_i) state_n = e_c_wait;
      e_c_wait: if (rev_v_i)         state_n = e_c_ack;
      e_c_ack:                       state_n = e_c_idle;
      default:                       state_n = e_c_idle;
    endcase
  end

  always_ff @(posedge clk_i) begin
    if (!rst_n_i) begin
      state_r <= e_c_idle;
    end else begin
      state_r <= state_n;
    end
  end

  // Capture the bus request as a low-aligned message.
  always_ff @(posedge clk_i) begin
    if (bus_start) begin
      op_r   <= wb_we_i ? e_mem_wr : e_mem_rd;
      addr_r <= {wb_adr_i, sel_offset};
      size_r <= sel_size;
      if (wb_we_i) begin
        data_r <= (wb_dat_i >> {sel_offset, 3'b000}) & size_to_data_mask(sel_size);
      end else begin
        data_r <= '0;
      end
    end
  end

  // Memory answers low-aligned; move it back up to the request lanes.
  always_ff @(posedge clk_i) begin
    if (rev_accept) begin
      rdata_r <= (rev_data_i & size_to_data_mask(size_r))
                 << {addr_r[offset_width_gp-1:0], 3'b000};
    end
  end

  assign fwd_op_o   = op_r;
  assign fwd_addr_o = addr_r;
  assign fwd_size_o = size_r;
  assign fwd_data_o = data_r;
  assign wb_dat_o   = rdata_r;

endmodule

`default_nettype wire

// ==== src/wb_bridge_top.sv ====
`default_nettype none

module wb_bridge_top
  import wbb_pkg::*;
#(
  parameter  int addr_width_p    = 40,
  localparam int wb_adr_width_lp = addr_width_p - offset_width_gp
) (
  input  logic                     clk_i,
  input  logic                     rst_n_i,

  // Master forward in.
  input  mem_op_e                  m_fwd_op_i,
  input  logic [addr_width_p-1:0]  m_fwd_addr_i,
  input  mem_size_e                m_fwd_size_i,
  input  logic [data_width_gp-1:0] m_fwd_data_i,
  input  logic                     m_fwd_v_i,
  output logic                     m_fwd_ready_and_o,

  // Master reverse out.
  output mem_op_e                  m_rev_op_o,
  output logic [addr_width_p-1:0]  m_rev_addr_o,
  output mem_size_e                m_rev_size_o,
  output logic [data_width_gp-1:0] m_rev_data_o,
  output logic                     m_rev_v_o,
  input  logic                     m_rev_ready_and_i,

  // Client forward out.
  output mem_op_e                  c_fwd_op_o,
  output logic [addr_width_p-1:0]  c_fwd_addr_o,
  output mem_size_e                c_fwd_size_o,
  output logic [data_width_gp-1:0] c_fwd_data_o,
  output logic                     c_fwd_v_o,
  input  logic                     c_fwd_ready_and_i,

  // Client reverse in.
  input  logic [data_width_gp-1:0] c_rev_data_i,
  input  logic                     c_rev_v_i,
  output logic                     c_rev_ready_and_o
);

  // Internal Wishbone bus between the adapters.
  logic [wb_adr_width_lp-1:0] wb_adr;
  logic [data_width_gp-1:0]   wb_dat_mosi;
  logic [sel_width_gp-1:0]    wb_sel;
  logic                       wb_we;
  logic                       wb_cyc;
  logic                       wb_stb;
  logic [data_width_gp-1:0]   wb_dat_miso;
  logic                       wb_ack;

  wb_master #(
    .addr_width_p(addr_width_p)
  ) u_master (
    .clk_i          (clk_i),
    .rst_n_i        (rst_n_i),
    .fwd_op_i       (m_fwd_op_i),
    .fwd_addr_i     (m_fwd_addr_i),
    .fwd_size_i     (m_fwd_size_i),
    .fwd_data_i     (m_fwd_data_i),
    .fwd_v_i        (m_fwd_v_i),
    .fwd_ready_and_o(m_fwd_ready_and_o),
    .rev_op_o       (m_rev_op_o),
    .rev_addr_o     (m_rev_addr_o),
    .rev_size_o     (m_rev_size_o),
    .rev_data_o     (m_rev_data_o),
    .rev_v_o        (m_rev_v_o),
    .rev_ready_and_i(m_rev_ready_and_i),
    .wb_adr_o       (wb_adr),
    .wb_dat_o       (wb_dat_mosi),
    .wb_sel_o       (wb_sel),
    .wb_we_o        (wb_we),
    .wb_cyc_o       (wb_cyc),
    .wb_stb_o       (wb_stb),
    .wb_dat_i       (wb_dat_miso),
    .wb_ack_i       (wb_ack)
  );

  wb_client #(
    .addr_width_p(addr_width_p)
  ) u_client (
    .clk_i          (clk_i),
    .rst_n_i        (rst_n_i),
    .wb_adr_i       (wb_adr),
    .wb_dat_i       (wb_dat_mosi),
    .wb_sel_i       (wb_sel),
    .wb_we_i        (wb_we),
    .wb_cyc_i       (wb_cyc),
    .wb_stb_i       (wb_stb),
    .wb_dat_o       (wb_dat_miso),
    .wb_ack_o       (wb_ack),
    .fwd_op_o       (c_fwd_op_o),
    .fwd_addr_o     (c_fwd_addr_o),
    .fwd_size_o     (c_fwd_size_o),
    .fwd_data_o     (c_fwd_data_o),
    .fwd_v_o        (c_fwd_v_o),
    .fwd_ready_and_i(c_fwd_ready_and_i),
    .rev_data_i     (c_rev_data_i),
    .rev_v_i        (c_rev_v_i),
    .rev_ready_and_o(c_rev_ready_and_o)
  );

endmodule

`default_nettype wire

// ==== tests/wb_bridge_sva.sv ====
`default_nettype none

module wb_bridge_sva
  import wbb_pkg::*;
#(
  parameter int addr_width_p = 40
) (
  input logic                                    clk_i,
  input logic                                    rst_n_i,
  input logic [addr_width_p-offset_width_gp-1:0] wb_adr_i,
  input logic [data_width_gp-1:0]                wb_dat_i,
  input logic [sel_width_gp-1:0]                 wb_sel_i,
  input logic                                    wb_we_i,
  input logic                                    wb_cyc_i,
  input logic                                    wb_stb_i,
  input logic                                    wb_ack_i,
  input logic [addr_width_p-1:0]                 m_fwd_addr_i,
  input mem_size_e                               m_fwd_size_i,
  input logic                                    m_fwd_v_i,
  input logic                                    m_fwd_ready_i,
  input logic                                    m_rev_v_i,
  input logic                                    m_rev_ready_i,
  input logic                                    c_fwd_v_i,
  input logic                                    c_fwd_ready_i,
  input logic                                    c_rev_v_i,
  input logic                                    c_rev_ready_i
);

  // Failed assertions so far.
  int fail_count = 0;

  property valid_held(v, r);
    @(posedge clk_i) disable iff (!rst_n_i) v && !r |=> v;
  endproperty

  a_stb_cyc: assert property (@(posedge clk_i) disable iff (!rst_n_i) wb_stb_i |-> wb_cyc_i)
    else begin
      $error("wishbone stb high without cyc");
      fail_count++;
    end

  // Master fields frozen until the client acks.
  a_wb_stable: assert property (@(posedge clk_i) disable iff (!rst_n_i)
    wb_stb_i && !wb_ack_i |=> wb_stb_i && $stable(wb_adr_i) && $stable(wb_dat_i) &&
                              $stable(wb_sel_i) && $stable(wb_we_i))
    else begin
      $error("wishbone request changed before ack");
      fail_count++;
    end

  a_ack_stb: assert property (@(posedge clk_i) disable iff (!rst_n_i) wb_ack_i |-> wb_stb_i)
    else begin
      $error("wishbone ack without stb");
      fail_count++;
    end

  a_m_fwd_hold: assert property (valid_held(m_fwd_v_i, m_fwd_ready_i))
    else begin
      $error("master forward valid dropped before ready");
      fail_count++;
    end
  a_m_rev_hold: assert property (valid_held(m_rev_v_i, m_rev_ready_i))
    else begin
      $error("master reverse valid dropped before ready");
      fail_count++;
    end
  a_c_fwd_hold: assert property (valid_held(c_fwd_v_i, c_fwd_ready_i))
    else begin
      $error("client forward valid dropped before ready");
      fail_count++;
    end
  a_c_rev_hold: assert property (valid_held(c_rev_v_i, c_rev_ready_i))
    else begin
      $error("client reverse valid dropped before ready");
      fail_count++;
    end

  a_fwd_aligned: assert property (@(posedge clk_i) disable iff (!rst_n_i)
    m_fwd_v_i |-> (m_fwd_addr_i[offset_width_gp-1:0] & ((4'd1 << m_fwd_size_i) - 4'd1)) == 0)
    else begin
      $error("master forward address not aligned to its size");
      fail_count++;
    end

endmodule

bind wb_bridge_top wb_bridge_sva #(
  .addr_width_p(addr_width_p)
) u_sva (
  .clk_i        (clk_i),
  .rst_n_i      (rst_n_i),
  .wb_adr_i     (wb_adr),
  .wb_dat_i     (wb_dat_mosi),
  .wb_sel_i     (wb_sel),
  .wb_we_i      (wb_we),
  .wb_cyc_i     (wb_cyc),
  .wb_stb_i     (wb_stb),
  .wb_ack_i     (wb_ack),
  .m_fwd_addr_i (m_fwd_addr_i),
  .m_fwd_size_i (m_fwd_size_i),
  .m_fwd_v_i    (m_fwd_v_i),
  .m_fwd_ready_i(m_fwd_ready_and_o),
  .m_rev_v_i    (m_rev_v_o),
  .m_rev_ready_i(m_rev_ready_and_i),
  .c_fwd_v_i    (c_fwd_v_o),
  .c_fwd_ready_i(c_fwd_ready_and_i),
  .c_rev_v_i    (c_rev_v_i),
  .c_rev_ready_i(c_rev_ready_and_o)
);

`default_nettype wire

// ==== tests/wb_bridge_tb.sv ====
`default_nettype none

module wb_bridge_tb
  import wbb_pkg::*;
();

  localparam int addr_width_lp     = 40;
  localparam int n_directed_lp     = 20;
  localparam int n_total_lp        = 400;
  localparam int timeout_cycles_lp = n_total_lp * 40;
  localparam int latency_lp        = 6;
  localparam int win_bytes_lp      = 256 * 8;
  localparam logic [addr_width_lp-1:0] base_addr_lp = 40'h00_4000_0000;

  typedef struct packed {
    mem_op_e                  op;
    logic [addr_width_lp-1:0] addr;
    mem_size_e                size;
    logic [data_width_gp-1:0] data;
  } msg_t;

  logic                     clk_i;
  logic                     rst_n_i;
  mem_op_e                  m_fwd_op_i;
  logic [addr_width_lp-1:0] m_fwd_addr_i;
  mem_size_e                m_fwd_size_i;
  logic [data_width_gp-1:0] m_fwd_data_i;
  logic                     m_fwd_v_i;
  logic                     m_fwd_ready_and_o;
  mem_op_e                  m_rev_op_o;
  logic [addr_width_lp-1:0] m_rev_addr_o;
  mem_size_e                m_rev_size_o;
  logic [data_width_gp-1:0] m_rev_data_o;
  logic                     m_rev_v_o;
  logic                     m_rev_ready_and_i;
  mem_op_e                  c_fwd_op_o;
  logic [addr_width_lp-1:0] c_fwd_addr_o;
  mem_size_e                c_fwd_size_o;
  logic [data_width_gp-1:0] c_fwd_data_o;
  logic                     c_fwd_v_o;
  logic                     c_fwd_ready_and_i;
  logic [data_width_gp-1:0] c_rev_data_i;
  logic                     c_rev_v_i;
  logic                     c_rev_ready_and_o;

  logic [31:0]              lfsr_q;
  logic [7:0]               mem_q [win_bytes_lp];
  logic [7:0]               ref_q [win_bytes_lp];
  msg_t                     fwd_exp_q [$];
  msg_t                     rev_exp_q [$];
  int                       errors = 0;
  int                       checks = 0;
  int                       issued = 0;
  int                       rev_count = 0;
  int                       cycle_count = 0;
  int                       start_cycle = 0;
  int                       mem_wait = 0;
  logic                     mem_pend = 1'b0;
  logic                     mem_new = 1'b0;
  logic                     fwd_taken = 1'b0;
  logic                     rev_v_prev = 1'b0;
  logic                     stim_on = 1'b0;
  logic                     in_directed;
  logic [data_width_gp-1:0] mem_rdata = '0;

  wb_bridge_top #(
    .addr_width_p(addr_width_lp)
  ) u_wb_bridge_top (.*);

  initial begin
    clk_i = 1'b0;
    forever begin
      #2;
      clk_i = ~clk_i;
    end
  end

  // Fibonacci LFSR, taps 32 22 2 1, one step per bit.
  function automatic logic [63:0] rand_bits(input int n);
    logic [63:0] val;
    logic        fb;
    val = '0;
    for (int i = 0; i < n; i++) begin
      fb     = lfsr_q[31] ^ lfsr_q[21] ^ lfsr_q[1] ^ lfsr_q[0];
      lfsr_q = {lfsr_q[30:0], fb};
      val    = {val[62:0], fb};
    end
    return val;
  endfunction

  function automatic int num_bytes(input mem_size_e size);
    return 1 << int'(size);
  endfunction

  function automatic logic [7:0] fill_byte(input logic [addr_width_lp-1:0] a);
    return a[7:0] ^ a[15:8] ^ a[23:16] ^ a[31:24] ^ a[39:32] ^ 8'h3c;
  endfunction

  task automatic check_rev(input string name, input msg_t exp, input mem_op_e op,
                           input logic [addr_width_lp-1:0] addr, input mem_size_e size,
                           input logic [data_width_gp-1:0] data);
    checks++;
    if (op !== exp.op || addr !== exp.addr || size !== exp.size || data !== exp.data) begin
      errors++;
      $display("CHECK FAILED %s: expected op=%s addr=%h size=%s data=%h, actual %s %h %s %h",
               name, exp.op.name(), exp.addr, exp.size.name(), exp.data,
               op.name(), addr, size.name(), data);
    end
  endtask

  // Data is only meaningful on writes.
  task automatic check_fwd(input string name, input msg_t exp, input mem_op_e op,
                           input logic [addr_width_lp-1:0] addr, input mem_size_e size,
                           input logic [data_width_gp-1:0] data);
    checks++;
    if (op !== exp.op || addr !== exp.addr || size !== exp.size ||
        (exp.op == e_mem_wr && data !== exp.data)) begin
      errors++;
      $display("CHECK FAILED %s: expected op=%s addr=%h size=%s data=%h, actual %s %h %s %h",
               name, exp.op.name(), exp.addr, exp.size.name(), exp.data,
               op.name(), addr, size.name(), data);
    end
  endtask

  task automatic check_flag(input string name, input logic exp, input logic act);
    checks++;
    if (act !== exp) begin
      errors++;
      $display("CHECK FAILED %s: expected %b, actual %b", name, exp, act);
    end
  endtask

  task automatic check_latency(input string name, input int exp, input int act);
    checks++;
    if (act != exp) begin
      errors++;
      $display("CHECK FAILED %s: expected %0d cycles, actual %0d cycles", name, exp, act);
    end
  endtask

  task automatic check_byte(input string name, input logic [7:0] exp, input logic [7:0] act);
    checks++;
    if (act !== exp) begin
      errors++;
      $display("CHECK FAILED %s: expected %h, actual %h", name, exp, act);
    end
  endtask

  // New master request; the reference memory is updated in request order.
  task automatic issue_request();
    msg_t       req;
    msg_t       fwd;
    msg_t       rsp;
    logic [1:0] sz;
    int         nb;
    int         off;
    int         idx;
    req.op   = rand_bits(1) ? e_mem_wr : e_mem_rd;
    sz       = rand_bits(2);
    req.size = mem_size_e'(sz);
    nb       = num_bytes(req.size);
    off      = int'(rand_bits(3));
    off      = off - (off % nb);
    idx      = int'(rand_bits(8)) * 8 + off;
    req.addr = base_addr_lp + idx;
    req.data = rand_bits(64);
    fwd      = req;
    fwd.data = '0;
    rsp      = req;
    rsp.data = '0;
    for (int i = 0; i < nb; i++) begin
      fwd.data[8*i+:8] = req.data[8*i+:8];
      if (req.op == e_mem_wr) begin
        ref_q[idx+i] = req.data[8*i+:8];
      end else begin
        rsp.data[8*i+:8] = ref_q[idx+i];
      end
    end
    fwd_exp_q.push_back(fwd);
    rev_exp_q.push_back(rsp);
    m_fwd_op_i   = req.op;
    m_fwd_addr_i = req.addr;
    m_fwd_size_i = req.size;
    m_fwd_data_i = req.data;
    m_fwd_v_i    = 1'b1;
    issued++;
  endtask

  // Downstream memory takes the client forward message.
  task automatic serve_forward();
    int idx;
    if (fwd_exp_q.size() == 0) begin
      errors++;
      $display("client sent a forward message with no request outstanding");
    end else begin
      check_fwd($sformatf("client forward %0d", rev_count), fwd_exp_q.pop_front(),
                c_fwd_op_o, c_fwd_addr_o, c_fwd_size_o, c_fwd_data_o);
    end
    mem_rdata = '0;
    if (c_fwd_addr_o < base_addr_lp || c_fwd_addr_o >= base_addr_lp + win_bytes_lp) begin
      errors++;
      $display("client forward address %h lies outside the memory window", c_fwd_addr_o);
    end else begin
      idx = int'(c_fwd_addr_o - base_addr_lp);
      for (int i = 0; i < num_bytes(c_fwd_size_o) && idx + i < win_bytes_lp; i++) begin
        if (c_fwd_op_o == e_mem_wr) begin
          mem_q[idx+i] = c_fwd_data_o[8*i+:8];
        end else begin
          mem_rdata[8*i+:8] = mem_q[idx+i];
        end
      end
    end
    mem_pend = 1'b1;
    mem_new  = 1'b1;
  endtask

  task automatic take_reverse();
    if (rev_exp_q.size() == 0) begin
      errors++;
      $display("master returned a reverse message with no request outstanding");
    end else begin
      check_rev($sformatf("master reverse %0d", rev_count), rev_exp_q.pop_front(),
                m_rev_op_o, m_rev_addr_o, m_rev_size_o, m_rev_data_o);
    end
    rev_count++;
  endtask

  // All stimulus, bubbles and memory answers change on the falling edge.
  always @(negedge clk_i) begin
    if (stim_on) begin
      in_directed = (rev_count < n_directed_lp);
      if (in_directed) begin
        m_rev_ready_and_i = 1'b1;
        c_fwd_ready_and_i = 1'b1;
      end else begin
        m_rev_ready_and_i = (rand_bits(2) != 0);
        c_fwd_ready_and_i = (rand_bits(2) != 0);
      end
      // One idle cycle before the answer in the directed phase.
      if (mem_new) begin
        mem_wait = in_directed ? 1 : int'(rand_bits(2));
        mem_new  = 1'b0;
      end
      c_rev_v_i    = mem_pend && (mem_wait == 0);
      c_rev_data_i = mem_rdata;
      if (mem_pend && mem_wait > 0) begin
        mem_wait--;
      end
      if (!m_fwd_v_i || fwd_taken) begin
        fwd_taken = 1'b0;
        if (issued < (in_directed ? n_directed_lp : n_total_lp) &&
            (in_directed || rand_bits(2) != 0)) begin
          issue_request();
        end else begin
          m_fwd_v_i = 1'b0;
        end
      end
    end
  end

  always @(posedge clk_i) begin
    cycle_count++;
    if (m_fwd_v_i && m_fwd_ready_and_o) begin
      fwd_taken   = 1'b1;
      start_cycle = cycle_count;
    end
    if (c_rev_v_i && c_rev_ready_and_o) begin
      mem_pend = 1'b0;
    end
    if (c_fwd_v_o && c_fwd_ready_and_i) begin
      serve_forward();
    end
    if (m_rev_v_o && !rev_v_prev && rev_count < n_directed_lp) begin
      check_latency($sformatf("latency %0d", rev_count), latency_lp,
                    cycle_count - start_cycle);
    end
    if (m_rev_v_o && m_rev_ready_and_i) begin
      take_reverse();
    end
    rev_v_prev = m_rev_v_o;
  end

  initial begin
    repeat (timeout_cycles_lp) @(posedge clk_i);
    $display("timeout after %0d cycles, %0d of %0d responses seen",
             timeout_cycles_lp, rev_count, n_total_lp);
    $display("sim failed");
    $finish;
  end

  initial begin
    lfsr_q            = 32'hd5992281;
    rst_n_i           = 1'b0;
    m_fwd_op_i        = e_mem_rd;
    m_fwd_addr_i      = '0;
    m_fwd_size_i      = e_size_1;
    m_fwd_data_i      = '0;
    m_fwd_v_i         = 1'b0;
    m_rev_ready_and_i = 1'b0;
    c_fwd_ready_and_i = 1'b0;
    c_rev_data_i      = '0;
    c_rev_v_i         = 1'b0;
    for (int i = 0; i < win_bytes_lp; i++) begin
      mem_q[i] = fill_byte(base_addr_lp + i);
      ref_q[i] = fill_byte(base_addr_lp + i);
    end
    repeat (10) @(negedge clk_i);
    check_flag("reset m_rev_v_o", 1'b0, m_rev_v_o);
    check_flag("reset c_fwd_v_o", 1'b0, c_fwd_v_o);
    check_flag("reset m_fwd_ready_and_o", 1'b1, m_fwd_ready_and_o);
    check_flag("reset c_rev_ready_and_o", 1'b0, c_rev_ready_and_o);
    rst_n_i = 1'b1;
    @(posedge clk_i);
    stim_on = 1'b1;
    while (rev_count < n_total_lp) @(negedge clk_i);
    repeat (10) @(negedge clk_i);
    if (fwd_exp_q.size() != 0 || rev_exp_q.size() != 0 || issued != rev_count) begin
      errors++;
      $display("requests and responses do not match up at the end of the run");
    end
    // Every byte of the downstream memory, touched or not.
    for (int i = 0; i < win_bytes_lp; i++) begin
      check_byte($sformatf("memory byte %h", base_addr_lp + i), ref_q[i], mem_q[i]);
    end
    if (u_wb_bridge_top.u_sva.fail_count != 0) begin
      errors += u_wb_bridge_top.u_sva.fail_count;
      $display("%0d bus or handshake assertions failed", u_wb_bridge_top.u_sva.fail_count);
    end
    $display("transactions %0d, checks %0d, errors %0d", rev_count, checks, errors);
    if (errors == 0) begin
      $display("sim passed");
    end else begin
      $display("sim failed");
    end
    $finish;
  end

endmodule

`default_nettype wire

// ==== wb_bridge.f ====
common/wbb_pkg.sv
wb_master/mem_fwd_decode.sv
wb_master/wb_master.sv
wb_client/wb_client.sv
src/wb_bridge_top.sv
tests/wb_bridge_sva.sv
tests/wb_bridge_tb.sv

// ==== Bender.yml ====
package:
  name: wb_bridge

sources:
  - common/wbb_pkg.sv
  - wb_master/mem_fwd_decode.sv
  - wb_master/wb_master.sv
  - wb_client/wb_client.sv
  - src/wb_bridge_top.sv
  - target: test
    files:
      - tests/wb_bridge_sva.sv
      - tests/wb_bridge_tb.sv
